//--- fmul_unit.f
src/fmul_pkg.sv
src/fp_classify.sv
src/mant_mul.sv
src/fmul_core.sv
src/fmul_csr.sv
src/fmul_unit.sv
tests/fmul_unit_assert.sv
tests/fmul_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fmul_unit testbench with Verilator.
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module fmul_unit_tb \
    -f fmul_unit.f -o fmul_unit_sim \
    && ./obj_dir/fmul_unit_sim > sim.log 2>&1
grep -q "^test passed$" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see sim.log"; exit 1; }

//--- tests/fmul_unit_tb.sv
`timescale 1ns/1ps

module fmul_unit_tb;
    import fmul_pkg::*;

    // the tests take a few hundred cycles and 2000 leaves a wide margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        reset_i;
    fmul_req_t   req;
    fmul_rsp_t   rsp;
    logic        awvalid;
    logic        awready;
    logic [31:0] awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    axi_resp_e   bresp;
    logic        arvalid;
    logic        arready;
    logic [31:0] araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    axi_resp_e   rresp;

    int          cycles = 0;
    integer      seed;
    fmul_rsp_t   exp_q[$];
    fmul_req_t   req_q[$];
    int          due_q[$];
    fflags_t     acc_flags;
    round_mode_e cur_frm;

    fmul_unit dut (
        .clk       (clk),
        .reset_i   (reset_i),
        .req_i     (req),
        .rsp_o     (rsp),
        .awvalid_i (awvalid),
        .awready_o (awready),
        .awaddr_i  (awaddr),
        .wvalid_i  (wvalid),
        .wready_o  (wready),
        .wdata_i   (wdata),
        .bvalid_o  (bvalid),
        .bready_i  (bready),
        .bresp_o   (bresp),
        .arvalid_i (arvalid),
        .arready_o (arready),
        .araddr_i  (araddr),
        .rvalid_o  (rvalid),
        .rready_i  (rready),
        .rdata_o   (rdata),
        .rresp_o   (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_with(input string line);
        $display("%s", line);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            abort_with($sformatf("timeout after %0d cycles, the tests did not finish",
                                 TIMEOUT_CYCLES));
        end
    end

    task automatic compare_fp(input fp32_t got, input fp32_t expv, input string what);
        if (got !== expv) begin
            abort_with($sformatf("CHECK FAILED at %0t: %s result %h, expected %h",
                                 $time, what, got, expv));
        end
    endtask

    task automatic compare_flags(input fflags_t got, input fflags_t expv, input string what);
        if (got !== expv) begin
            abort_with($sformatf("CHECK FAILED at %0t: %s flags %b, expected %b",
                                 $time, what, got, expv));
        end
    endtask

    task automatic compare_resp(input axi_resp_e got, input axi_resp_e expv, input string what);
        if (got !== expv) begin
            abort_with($sformatf("CHECK FAILED at %0t: %s response %b, expected %b",
                                 $time, what, got, expv));
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] expv,
                                input string what);
        if (got !== expv) begin
            abort_with($sformatf("CHECK FAILED at %0t: %s read %h, expected %h",
                                 $time, what, got, expv));
        end
    endtask

    // reference multiply built from the class, rounding and range rules.
    function automatic fmul_rsp_t model_mul(input fmul_op_e op, input round_mode_e rm,
                                            input fp32_t a, input fp32_t b);
        fmul_rsp_t   r;
        logic        sign;
        logic        a_nan;
        logic        b_nan;
        logic        a_inf;
        logic        b_inf;
        logic        a_zero;
        logic        b_zero;
        logic        snan;
        logic        up;
        logic [47:0] prod;
        logic [47:0] rem;
        logic [47:0] half;
        logic [24:0] keep;
        int          e;
        int          sh;
        r       = '0;
        r.valid = 1'b1;
        sign    = a.sign ^ b.sign ^ (op == OP_FNMUL);
        a_nan   = (a.exp == 8'hff) && (a.mant != 23'd0);
        b_nan   = (b.exp == 8'hff) && (b.mant != 23'd0);
        a_inf   = (a.exp == 8'hff) && (a.mant == 23'd0);
        b_inf   = (b.exp == 8'hff) && (b.mant == 23'd0);
        a_zero  = (a.exp == 8'h00);
        b_zero  = (b.exp == 8'h00);
        snan    = (a_nan && !a.mant[22]) || (b_nan && !b.mant[22]);
        if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            r.result   = CANON_NAN;
            r.flags.nv = 1'b1;
        end else if (a_nan || b_nan) begin
            r.result   = CANON_NAN;
            r.flags.nv = snan;
        end else if (a_inf || b_inf) begin
            r.result = {sign, 8'hff, 23'd0};
        end else if (a_zero || b_zero) begin
            r.result = {sign, 31'd0};
        end else begin
            prod = {24'd0, 1'b1, a.mant} * {24'd0, 1'b1, b.mant};
            e    = int'(a.exp) + int'(b.exp) - FP_BIAS;
            sh   = prod[47] ? 24 : 23;
            if (prod[47]) begin
                e = e + 1;
            end
            keep = 25'(prod >> sh);
            rem  = prod & ((48'd1 << sh) - 48'd1);
            half = 48'd1 << (sh - 1);
            case (rm)
                RTZ:     up = 1'b0;
                RDN:     up = sign && (rem != 48'd0);
                RUP:     up = !sign && (rem != 48'd0);
                RMM:     up = (rem >= half);
                default: up = (rem > half) || ((rem == half) && keep[0]);
            endcase
            keep = keep + 25'(up);
            if (keep[24]) begin
                keep = keep >> 1;
                e    = e + 1;
            end
            r.flags.nx = (rem != 48'd0);
            if (e > 254) begin
                r.flags.of = 1'b1;
                r.flags.nx = 1'b1;
                if (rm == RNE || rm == RMM || (rm == RUP && !sign) || (rm == RDN && sign)) begin
                    r.result = {sign, 8'hff, 23'd0};
                end else begin
                    r.result = {sign, MAX_FINITE_MAG.exp, MAX_FINITE_MAG.mant};
                end
            end else if (e < 1) begin
                r.flags.uf = 1'b1;
                r.flags.nx = 1'b1;
                r.result   = {sign, 31'd0};
            end else begin
                r.result = {sign, 8'(e), keep[22:0]};
            end
        end
        return r;
    endfunction

    function automatic fp32_t random_normal();
        logic [31:0] r;
        fp32_t       f;
        r      = $random(seed);
        f.sign = r[31];
        f.exp  = 8'd96 + {2'b00, r[29:24]};
        f.mant = r[22:0];
        return f;
    endfunction

    // the scoreboard samples outputs on the falling edge.
    always @(negedge clk) begin
        if (!reset_i) begin
            if (rsp.valid) begin
                if (exp_q.size() == 0) begin
                    abort_with("unexpected response: valid high with no request outstanding");
                end else if (due_q[0] != cycles) begin
                    abort_with($sformatf("response came in cycle %0d, expected in cycle %0d",
                                         cycles, due_q[0]));
                end else begin
                    compare_fp(rsp.result, exp_q[0].result,
                               $sformatf("a=%h b=%h rm=%0d", req_q[0].a, req_q[0].b,
                                         req_q[0].rm));
                    compare_flags(rsp.flags, exp_q[0].flags,
                                  $sformatf("a=%h b=%h", req_q[0].a, req_q[0].b));
                    void'(exp_q.pop_front());
                    void'(req_q.pop_front());
                    void'(due_q.pop_front());
                end
            end else if (exp_q.size() != 0 && due_q[0] <= cycles) begin
                abort_with($sformatf("response missing in cycle %0d", cycles));
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic send(input fmul_op_e op, input round_mode_e rm, input fp32_t a,
                        input fp32_t b);
        round_mode_e eff;
        fmul_rsp_t   expv;
        eff       = (rm == DYN) ? cur_frm : rm;
        expv      = model_mul(op, eff, a, b);
        acc_flags = acc_flags | expv.flags;
        req.valid = 1'b1;
        req.op    = op;
        req.rm    = rm;
        req.a     = a;
        req.b     = b;
        exp_q.push_back(expv);
        req_q.push_back(req);
        due_q.push_back(cycles + 3);
        step();
    endtask

    task automatic drain();
        req.valid = 1'b0;
        while (exp_q.size() != 0) begin
            step();
        end
        // fflags trails the last response by one cycle.
        step();
        step();
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             output axi_resp_e resp);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(negedge clk);
        while (!(awready && wready)) begin
            @(negedge clk);
        end
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // bready stays low for a cycle so bvalid has to hold.
        step();
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) begin
            @(negedge clk);
        end
        resp = bresp;
        step();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [31:0] addr, output logic [31:0] data,
                            output axi_resp_e resp);
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) begin
            @(negedge clk);
        end
        step();
        arvalid = 1'b0;
        // rready stays low for a cycle so rvalid has to hold.
        step();
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) begin
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        step();
        rready = 1'b0;
    endtask

    task automatic write_frm(input logic [31:0] data);
        axi_resp_e resp;
        axi_write(CSR_FRM_ADDR, data, resp);
        compare_resp(resp, RESP_OKAY, "frm write");
        cur_frm = (data[2:0] <= 3'd4) ? round_mode_e'(data[2:0]) : RNE;
    endtask

    task automatic exact_products();
        fmul_rsp_t ref_rsp;
        ref_rsp = model_mul(OP_FMUL, RNE, 32'h4000_0000, 32'h4040_0000);
        compare_fp(ref_rsp.result, 32'h40C0_0000, "model 2*3");
        send(OP_FMUL, RNE, 32'h4000_0000, 32'h4040_0000);
        send(OP_FMUL, RNE, 32'h3FC0_0000, 32'h3FC0_0000);
        send(OP_FMUL, RTZ, 32'h3F00_0000, 32'hC080_0000);
        send(OP_FNMUL, RNE, 32'h4040_0000, 32'h40A0_0000);
        send(OP_FNMUL, RUP, 32'hC000_0000, 32'h4000_0000);
        send(OP_FMUL, RNE, 32'h4480_0000, 32'h3E00_0000);
        drain();
    endtask

    task automatic rounding_modes();
        round_mode_e mode;
        for (int m = 0; m < 5; m++) begin
            mode = round_mode_e'(m[2:0]);
            repeat (8) begin
                send(OP_FMUL, mode, random_normal(), random_normal());
            end
        end
        drain();
        for (int m = 0; m < 5; m++) begin
            write_frm({29'd0, m[2:0]});
            repeat (6) begin
                send(m[0] ? OP_FNMUL : OP_FMUL, DYN, random_normal(), random_normal());
            end
            drain();
        end
    endtask

    task automatic special_cases();
        send(OP_FMUL, RNE, 32'h7F80_0000, 32'h0000_0000);
        send(OP_FMUL, RNE, 32'h8000_0000, 32'hFF80_0000);
        send(OP_FMUL, RNE, 32'h7FC0_0001, 32'h3F80_0000);
        send(OP_FMUL, RNE, 32'h7F80_0001, 32'h4000_0000);
        send(OP_FNMUL, RNE, 32'h3F80_0000, 32'hFF80_0005);
        send(OP_FMUL, RNE, 32'h7F80_0000, 32'hC000_0000);
        send(OP_FMUL, RNE, 32'h0000_0123, 32'h4040_0000);
        send(OP_FMUL, RNE, 32'h8040_0000, 32'h4040_0000);
        send(OP_FMUL, RNE, 32'h7F80_0000, 32'h0000_0001);
        drain();
    endtask

    task automatic overflow_underflow();
        round_mode_e mode;
        for (int m = 0; m < 5; m++) begin
            mode = round_mode_e'(m[2:0]);
            send(OP_FMUL, mode, 32'h7F00_0000, 32'h4040_0000);
            send(OP_FMUL, mode, 32'hFF00_0000, 32'h4000_0000);
            send(OP_FNMUL, mode, 32'h7E80_0000, 32'h7E80_0000);
            send(OP_FMUL, mode, 32'h0080_0000, 32'h0080_0000);
            send(OP_FMUL, mode, 32'h1F80_0000, 32'h9F80_0000);
        end
        drain();
    endtask

    task automatic register_access();
        logic [31:0] data;
        axi_resp_e   resp;
        axi_write(CSR_FFLAGS_ADDR, 32'd0, resp);
        compare_resp(resp, RESP_OKAY, "fflags clear");
        acc_flags = '0;
        send(OP_FMUL, RNE, 32'h7F80_0001, 32'h3F80_0000);
        send(OP_FMUL, RTZ, 32'h7F00_0000, 32'h7F00_0000);
        send(OP_FMUL, RNE, random_normal(), random_normal());
        drain();
        axi_read(CSR_FFLAGS_ADDR, data, resp);
        compare_resp(resp, RESP_OKAY, "fflags read");
        compare_word(data, {27'd0, acc_flags}, "fflags after nv and of");
        send(OP_FMUL, RNE, 32'h0080_0000, 32'h0080_0000);
        drain();
        axi_read(CSR_FFLAGS_ADDR, data, resp);
        compare_word(data, {27'd0, acc_flags}, "fflags after uf");
        axi_write(CSR_FFLAGS_ADDR, 32'd0, resp);
        acc_flags = '0;
        axi_read(CSR_FFLAGS_ADDR, data, resp);
        compare_word(data, 32'd0, "fflags after clear");
        for (int m = 0; m < 5; m++) begin
            write_frm({29'd0, m[2:0]});
            axi_read(CSR_FRM_ADDR, data, resp);
            compare_resp(resp, RESP_OKAY, "frm read");
            compare_word(data, {29'd0, m[2:0]}, "frm readback");
        end
        write_frm(32'd7);
        axi_read(CSR_FRM_ADDR, data, resp);
        compare_word(data, 32'd0, "frm after dyn write");
        write_frm(32'd3);
        write_frm(32'd5);
        axi_read(CSR_FRM_ADDR, data, resp);
        compare_word(data, 32'd0, "frm after reserved write");
        axi_read(32'h0000_0008, data, resp);
        compare_resp(resp, RESP_SLVERR, "unmapped read");
        compare_word(data, 32'd0, "unmapped read data");
        axi_write(32'h0000_000C, 32'h0000_001F, resp);
        compare_resp(resp, RESP_SLVERR, "unmapped write");
        axi_read(CSR_FFLAGS_ADDR, data, resp);
        compare_word(data, 32'd0, "fflags after unmapped write");
    endtask

    initial begin
        seed      = 32'h327b;
        reset_i   = 1'b1;
        req       = '0;
        awvalid   = 1'b0;
        awaddr    = 32'd0;
        wvalid    = 1'b0;
        wdata     = 32'd0;
        bready    = 1'b0;
        arvalid   = 1'b0;
        araddr    = 32'd0;
        rready    = 1'b0;
        acc_flags = '0;
        cur_frm   = RNE;
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        step();
        exact_products();
        rounding_modes();
        special_cases();
        overflow_underflow();
        register_access();
        $display("test passed");
        $finish;
    end

endmodule

//--- tests/fmul_unit_assert.sv
`timescale 1ns/1ps

module fmul_unit_assert (
    input logic clk,
    input logic reset_i,
    input logic req_valid_i,
    input logic rsp_valid_i,
    input logic bvalid_i,
    input logic bready_i,
    input logic rvalid_i,
    input logic rready_i
);

    // fixed three cycle latency through the pipeline.
    assert property (@(posedge clk) disable iff (reset_i)
        rsp_valid_i == $past(req_valid_i, 3))
        else $error("response valid does not follow request valid by three cycles");

    assert property (@(posedge clk) disable iff (reset_i)
        bvalid_i && !bready_i |=> bvalid_i)
        else $error("bvalid dropped before bready");

    assert property (@(posedge clk) disable iff (reset_i)
        rvalid_i && !rready_i |=> rvalid_i)
        else $error("rvalid dropped before rready");

    assert property (@(posedge clk) reset_i |=> !rsp_valid_i)
        else $error("response valid high during reset");

endmodule

bind fmul_unit fmul_unit_assert u_assert (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (req_i.valid),
    .rsp_valid_i (rsp_o.valid),
    .bvalid_i    (bvalid_o),
    .bready_i    (bready_i),
    .rvalid_i    (rvalid_o),
    .rready_i    (rready_i)
);

//--- src/fmul_unit.sv
`timescale 1ns/1ps

module fmul_unit (
    input  logic                clk,
    input  logic                reset_i,
    input  fmul_pkg::fmul_req_t req_i,
    output fmul_pkg::fmul_rsp_t rsp_o,
    input  logic                awvalid_i,
    output logic                awready_o,
    input  logic [31:0]         awaddr_i,
    input  logic                wvalid_i,
    output logic                wready_o,
    input  logic [31:0]         wdata_i,
    output logic                bvalid_o,
    input  logic                bready_i,
    output fmul_pkg::axi_resp_e bresp_o,
    input  logic                arvalid_i,
    output logic                arready_o,
    input  logic [31:0]         araddr_i,
    output logic                rvalid_o,
    input  logic                rready_i,
    output logic [31:0]         rdata_o,
    output fmul_pkg::axi_resp_e rresp_o
);
    import fmul_pkg::*;

    round_mode_e frm;

    fmul_core u_core (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req_i),
        .frm_i   (frm),
        .rsp_o   (rsp_o)
    );

    // responses also feed the sticky flag register.
    fmul_csr u_csr (
        .clk       (clk),
        .reset_i   (reset_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .awaddr_i  (awaddr_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .wdata_i   (wdata_i),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .bresp_o   (bresp_o),
        .arvalid_i (arvalid_i),
        .arready_o (arready_o),
        .araddr_i  (araddr_i),
        .rvalid_o  (rvalid_o),
        .rready_i  (rready_i),
        .rdata_o   (rdata_o),
        .rresp_o   (rresp_o),
        .rsp_i     (rsp_o),
        .frm_o     (frm)
    );

endmodule

//--- src/fmul_csr.sv
`timescale 1ns/1ps

module fmul_csr (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  awvalid_i,
    output logic                  awready_o,
    input  logic [31:0]           awaddr_i,
    input  logic                  wvalid_i,
    output logic                  wready_o,
    input  logic [31:0]           wdata_i,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    output fmul_pkg::axi_resp_e   bresp_o,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    input  logic [31:0]           araddr_i,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic [31:0]           rdata_o,
    output fmul_pkg::axi_resp_e   rresp_o,
    input  fmul_pkg::fmul_rsp_t   rsp_i,
    output fmul_pkg::round_mode_e frm_o
);
    import fmul_pkg::*;

    logic wr_fire;
    logic rd_fire;
    logic wr_frm;
    logic wr_fflags;
    round_mode_e frm_wr;
    fflags_t flags_in;
    fflags_t fflags_q;

    assign wr_fire   = awvalid_i & wvalid_i & ~bvalid_o;
    assign awready_o = wr_fire;
    assign wready_o  = wr_fire;
    assign rd_fire   = arvalid_i & ~rvalid_o;
    assign arready_o = ~rvalid_o;
    assign wr_frm    = wr_fire & (awaddr_i == CSR_FRM_ADDR);
    assign wr_fflags = wr_fire & (awaddr_i == CSR_FFLAGS_ADDR);
    assign flags_in  = rsp_i.valid ? rsp_i.flags : '0;

    // dyn and reserved encodings fall back to rne.
    always_comb begin
        case (wdata_i[2:0])
            3'd0, 3'd1, 3'd2, 3'd3, 3'd4: frm_wr = round_mode_e'(wdata_i[2:0]);
            default:                      frm_wr = RNE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bvalid_o <= 1'b0;
            frm_o    <= RNE;
            fflags_q <= '0;
        end else begin
            if (wr_fire) begin
                bvalid_o <= 1'b1;
            end else if (bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (wr_frm) begin
                frm_o <= frm_wr;
            end
            // a software write still keeps flags arriving in the same cycle.
            if (wr_fflags) begin
                fflags_q <= wdata_i[4:0] | flags_in;
            end else begin
                fflags_q <= fflags_q | flags_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp_o <= (wr_frm | wr_fflags) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rvalid_o <= 1'b0;
        end else if (rd_fire) begin
            rvalid_o <= 1'b1;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr_i)
                CSR_FRM_ADDR: begin
                    rdata_o <= {29'd0, frm_o};
                    rresp_o <= RESP_OKAY;
                end
                CSR_FFLAGS_ADDR: begin
                    rdata_o <= {27'd0, fflags_q};
                    rresp_o <= RESP_OKAY;
                end
                default: begin
                    rdata_o <= 32'd0;
                    rresp_o <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

//--- src/fmul_core.sv
`timescale 1ns/1ps

module fmul_core (
    input  logic                   clk,
    input  logic                   reset_i,
    input  fmul_pkg::fmul_req_t    req_i,
    input  fmul_pkg::round_mode_e  frm_i,
    output fmul_pkg::fmul_rsp_t    rsp_o
);
    import fmul_pkg::*;

    // side data carried next to the mantissa product.
    typedef struct packed {
        logic        valid;
        logic        sign;
        round_mode_e rm;
        logic [9:0]  exp;
        logic        special;
        fp32_t       spec_result;
        fflags_t     spec_flags;
    } side_t;

    fp_class_t cls_a;
    fp_class_t cls_b;
    logic zero_a;
    logic zero_b;
    logic sign_d;
    logic special_d;
    fp32_t spec_res_d;
    fflags_t spec_flags_d;
    round_mode_e rm_d;
    logic signed [9:0] exp_d;
    side_t s1_d;
    side_t s1_q;
    side_t s2_q;
    logic [47:0] prod;
    logic signed [9:0] exp_q;
    logic signed [9:0] exp_norm;
    logic signed [9:0] exp_rnd;
    logic [22:0] mant_norm;
    logic [23:0] mant_rnd;
    logic guard;
    logic sticky;
    logic inexact;
    logic round_up;
    logic ovf_inf;
    fp32_t norm_res;
    fflags_t norm_flags;

    fp_classify u_class_a (.operand_i(req_i.a), .class_o(cls_a));
    fp_classify u_class_b (.operand_i(req_i.b), .class_o(cls_b));

    mant_mul u_mant_mul (
        .clk       (clk),
        .a_i       ({|req_i.a.exp, req_i.a.mant}),
        .b_i       ({|req_i.b.exp, req_i.b.mant}),
        .product_o (prod)
    );

    assign zero_a = cls_a.is_zero | cls_a.is_sub;
    assign zero_b = cls_b.is_zero | cls_b.is_sub;
    assign sign_d = req_i.a.sign ^ req_i.b.sign ^ (req_i.op == OP_FNMUL);
    assign rm_d   = (req_i.rm == DYN) ? frm_i : req_i.rm;
    assign exp_d  = $signed({2'b00, req_i.a.exp}) + $signed({2'b00, req_i.b.exp})
                    - 10'(FP_BIAS);

    always_comb begin
        spec_res_d   = CANON_NAN;
        spec_flags_d = '0;
        special_d    = 1'b1;
        if ((cls_a.is_inf & zero_b) | (zero_a & cls_b.is_inf)) begin
            spec_flags_d.nv = 1'b1;
        end else if (cls_a.is_nan | cls_b.is_nan) begin
            spec_flags_d.nv = cls_a.is_snan | cls_b.is_snan;
        end else if (cls_a.is_inf | cls_b.is_inf) begin
            spec_res_d = '{sign: sign_d, exp: 8'hff, mant: 23'd0};
        end else if (zero_a | zero_b) begin
            spec_res_d = '{sign: sign_d, exp: 8'h00, mant: 23'd0};
        end else begin
            special_d = 1'b0;
        end
    end

    assign s1_d = '{valid: req_i.valid, sign: sign_d, rm: rm_d, exp: exp_d,
                    special: special_d, spec_result: spec_res_d, spec_flags: spec_flags_d};

    always_ff @(posedge clk) begin
        s1_q <= s1_d;
        s2_q <= s1_q;
        if (reset_i) begin
            s1_q.valid <= 1'b0;
            s2_q.valid <= 1'b0;
        end
    end

    // stage 3, normalize by one bit, round, then range check.
    always_comb begin
        exp_q = $signed(s2_q.exp);
        if (prod[47]) begin
            mant_norm = prod[46:24];
            guard     = prod[23];
            sticky    = |prod[22:0];
            exp_norm  = exp_q + 10'sd1;
        end else begin
            mant_norm = prod[45:23];
            guard     = prod[22];
            sticky    = |prod[21:0];
            exp_norm  = exp_q;
        end
        inexact = guard | sticky;
        case (s2_q.rm)
            RTZ:     round_up = 1'b0;
            RDN:     round_up = s2_q.sign & inexact;
            RUP:     round_up = ~s2_q.sign & inexact;
            RMM:     round_up = guard;
            default: round_up = guard & (sticky | mant_norm[0]);
        endcase
        case (s2_q.rm)
            RTZ:     ovf_inf = 1'b0;
            RDN:     ovf_inf = s2_q.sign;
            RUP:     ovf_inf = ~s2_q.sign;
            default: ovf_inf = 1'b1;
        endcase
        mant_rnd      = {1'b0, mant_norm} + 24'(round_up);
        exp_rnd       = mant_rnd[23] ? exp_norm + 10'sd1 : exp_norm;
        norm_flags    = '0;
        norm_flags.nx = inexact;
        norm_res      = '{sign: s2_q.sign, exp: exp_rnd[7:0], mant: mant_rnd[22:0]};
        if (exp_rnd > 10'sd254) begin
            norm_flags.of = 1'b1;
            norm_flags.nx = 1'b1;
            if (ovf_inf) begin
                norm_res = '{sign: s2_q.sign, exp: 8'hff, mant: 23'd0};
            end else begin
                norm_res = '{sign: s2_q.sign, exp: MAX_FINITE_MAG.exp,
                             mant: MAX_FINITE_MAG.mant};
            end
        end else if (exp_rnd < 10'sd1) begin
            norm_flags.uf = 1'b1;
            norm_flags.nx = 1'b1;
            norm_res      = '{sign: s2_q.sign, exp: 8'h00, mant: 23'd0};
        end
    end

    always_ff @(posedge clk) begin
        rsp_o.result <= s2_q.special ? s2_q.spec_result : norm_res;
        rsp_o.flags  <= s2_q.special ? s2_q.spec_flags : norm_flags;
        if (reset_i) begin
            rsp_o.valid <= 1'b0;
        end else begin
            rsp_o.valid <= s2_q.valid;
        end
    end

endmodule

//--- src/mant_mul.sv
`timescale 1ns/1ps

module mant_mul (
    input  logic        clk,
    input  logic [23:0] a_i,
    input  logic [23:0] b_i,
    output logic [47:0] product_o
);

    logic [35:0] pp_lo_q;
    logic [35:0] pp_hi_q;

    // stage 1 forms two 24x12 partial products.
    always_ff @(posedge clk) begin
        pp_lo_q <= 36'(a_i) * 36'(b_i[11:0]);
        pp_hi_q <= 36'(a_i) * 36'(b_i[23:12]);
    end

    // stage 2 aligns the upper half and sums.
    always_ff @(posedge clk) begin
        product_o <= {pp_hi_q, 12'd0} + {12'd0, pp_lo_q};
    end

endmodule

//--- src/fp_classify.sv
`timescale 1ns/1ps

module fp_classify (
    input  fmul_pkg::fp32_t     operand_i,
    output fmul_pkg::fp_class_t class_o
);

    logic exp_zero;
    logic exp_ones;
    logic mant_zero;

    assign exp_zero  = (operand_i.exp == 8'h00);
    assign exp_ones  = (operand_i.exp == 8'hff);
    assign mant_zero = (operand_i.mant == 23'd0);

    // subnormals are flagged separately, the core folds them into zero.
    assign class_o.is_zero = exp_zero & mant_zero;
    assign class_o.is_sub  = exp_zero & ~mant_zero;
    assign class_o.is_inf  = exp_ones & mant_zero;
    assign class_o.is_nan  = exp_ones & ~mant_zero;

    // quiet bit is the mantissa msb.
    assign class_o.is_snan = exp_ones & ~mant_zero & ~operand_i.mant[22];

endmodule

//--- src/fmul_pkg.sv
package fmul_pkg;

    localparam int FP_BIAS = 127;

    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [22:0] mant;
    } fp32_t;

    // bit order matches the RISC-V fflags csr.
    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4,
        DYN = 3'd7
    } round_mode_e;

    typedef enum logic {
        OP_FMUL  = 1'b0,
        OP_FNMUL = 1'b1
    } fmul_op_e;

    typedef struct packed {
        logic is_zero;
        logic is_sub;
        logic is_inf;
        logic is_nan;
        logic is_snan;
    } fp_class_t;

    typedef struct packed {
        logic        valid;
        fmul_op_e    op;
        round_mode_e rm;
        fp32_t       a;
        fp32_t       b;
    } fmul_req_t;

    typedef struct packed {
        logic    valid;
        fp32_t   result;
        fflags_t flags;
    } fmul_rsp_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_e;

    localparam fp32_t CANON_NAN      = 32'h7FC0_0000;
    localparam fp32_t MAX_FINITE_MAG = 32'h7F7F_FFFF;

    localparam logic [31:0] CSR_FRM_ADDR    = 32'h0000_0000;
    localparam logic [31:0] CSR_FFLAGS_ADDR = 32'h0000_0004;

endpackage
